/* logic/sc_pkg.sv */
// Shared widths and register map; window exponent limited to 8..17, all widths tied to LFSR slicing
package sc_pkg;

  // Bipolar 9-bit value, 511 is close to +1
  typedef logic [8:0]  operand_t;
  typedef logic [30:0] lfsr_t;
  typedef logic [17:0] count_t;     // Holds up to 2^17
  typedef logic [4:0]  win_log2_t;
  typedef logic [7:0]  apb_addr_t;  // Byte address
  typedef logic [31:0] apb_data_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,  // One cycle, seed and clears
    RUN    // 2^L counting cycles
  } run_state_t;

  // LFSR seed and feedback taps
  localparam lfsr_t LFSR_SEED   = 31'd134995;
  localparam int    LFSR_TAP_HI = 30;
  localparam int    LFSR_TAP_LO = 27;

  localparam operand_t SEL_THRESHOLD = 9'd256;  // Select probability of 1/2

  localparam win_log2_t WIN_LOG2_MIN = 5'd8;
  localparam win_log2_t WIN_LOG2_MAX = 5'd17;
  localparam operand_t  RESULT_MAX   = 9'd511;

  // Register map
  localparam apb_addr_t ADDR_OPERAND_A = 8'h00;
  localparam apb_addr_t ADDR_OPERAND_B = 8'h04;
  localparam apb_addr_t ADDR_CTRL      = 8'h08;
  localparam apb_addr_t ADDR_STATUS    = 8'h0C;
  localparam apb_addr_t ADDR_RES_MUL   = 8'h10;
  localparam apb_addr_t ADDR_RES_ADD   = 8'h14;
  localparam apb_addr_t ADDR_RES_SQR   = 8'h18;

  // CTRL fields
  localparam int CTRL_START_BIT = 0;   // Write-one start
  localparam int CTRL_L_LSB     = 8;
  localparam int CTRL_L_MSB     = 12;

  // STATUS fields
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

/* logic/sc_apb_regs.sv */
// APB slave with no wait states; config writes rejected while busy, errored transfers change nothing
`timescale 1ns/1ns

module sc_apb_regs import sc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      busy,
  input  logic      done,
  input  operand_t  res_mul,
  input  operand_t  res_add,
  input  operand_t  res_sqr,
  output operand_t  operand_a,
  output operand_t  operand_b,
  output win_log2_t win_log2,
  output logic      start
);

  logic      access;     // Access phase, transfer takes effect here
  logic      locked;     // Run active or start pulse in flight
  logic      mapped;
  logic      wr_cfg;     // Write to operand or CTRL
  logic      start_req;
  logic      l_ok;
  logic      err;
  win_log2_t wr_l;       // L field of write data

  assign access = psel & penable;
  assign locked = busy | start;  // Covers the cycle before busy rises
  assign pready = 1'b1;

  assign wr_l = pwdata[CTRL_L_MSB:CTRL_L_LSB];
  assign l_ok = (wr_l >= WIN_LOG2_MIN) && (wr_l <= WIN_LOG2_MAX);

  // Address decode
  always_comb begin
    case (paddr)
      ADDR_OPERAND_A, ADDR_OPERAND_B, ADDR_CTRL, ADDR_STATUS,
      ADDR_RES_MUL, ADDR_RES_ADD, ADDR_RES_SQR: mapped = 1'b1;
      default:                                  mapped = 1'b0;
    endcase
  end

  assign wr_cfg    = pwrite && (paddr == ADDR_OPERAND_A || paddr == ADDR_OPERAND_B ||
                                paddr == ADDR_CTRL);
  assign start_req = pwrite && (paddr == ADDR_CTRL) && pwdata[CTRL_START_BIT];

  // Error sources, any one blocks the whole transfer
  assign err     = !mapped || (wr_cfg && locked) || (start_req && !l_ok);
  assign pslverr = access & err;

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      operand_a <= '0;
      operand_b <= '0;
      win_log2  <= WIN_LOG2_MIN;
      start     <= 1'b0;
    end else begin
      start <= access && start_req && !err;  // One-cycle pulse
      if (access && pwrite && !err) begin
        case (paddr)
          ADDR_OPERAND_A: operand_a <= operand_t'(pwdata);
          ADDR_OPERAND_B: operand_b <= operand_t'(pwdata);
          ADDR_CTRL: begin
            if (l_ok)
              win_log2 <= wr_l;  // Out-of-range L ignored without start
          end
          default: ;             // Read-only registers
        endcase
      end
    end
  end

  // Read mux, unused bits zero
  always_comb begin
    prdata = '0;
    case (paddr)
      ADDR_OPERAND_A: prdata = apb_data_t'(operand_a);
      ADDR_OPERAND_B: prdata = apb_data_t'(operand_b);
      ADDR_CTRL:      prdata[CTRL_L_MSB:CTRL_L_LSB] = win_log2;
      ADDR_STATUS: begin
        prdata[STATUS_BUSY_BIT] = locked;
        prdata[STATUS_DONE_BIT] = done;
      end
      ADDR_RES_MUL:   prdata = apb_data_t'(res_mul);
      ADDR_RES_ADD:   prdata = apb_data_t'(res_add);
      ADDR_RES_SQR:   prdata = apb_data_t'(res_sqr);
      default: ;
    endcase
  end

  // Error response only in access phase
  a_err_in_access: assert property (@(posedge clk) disable iff (rst_n)
    pslverr |-> (psel && penable));

endmodule

/* logic/sc_window_ctrl.sv */
// Run FSM; L must stay stable while busy, the register block enforces that
`timescale 1ns/1ns

module sc_window_ctrl import sc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  win_log2_t win_log2,
  output logic      load,
  output logic      run,
  output logic      last,
  output logic      busy,
  output logic      done
);

  run_state_t state;
  count_t     cnt;       // RUN cycle index
  count_t     win_len;   // 2^L

  assign win_len = count_t'(1) << win_log2;

  assign load = (state == LOAD);
  assign run  = (state == RUN);
  assign busy = (state != IDLE);
  assign last = run && (cnt == win_len - count_t'(1));  // Final window cycle

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      state <= IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= LOAD;
            done  <= 1'b0;  // Cleared by a new run
          end
        end
        LOAD: begin
          state <= RUN;
          cnt   <= '0;
        end
        RUN: begin
          if (last) begin
            state <= IDLE;
            done  <= 1'b1;
          end else begin
            cnt <= cnt + count_t'(1);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Start only accepted from idle
  a_start_not_busy: assert property (@(posedge clk) disable iff (rst_n)
    start |-> !busy);

  // Last inside RUN, then idle with done
  a_last_ends_run: assert property (@(posedge clk) disable iff (rst_n)
    last |-> run ##1 (done && !busy));

endmodule

/* logic/sc_stream_gen.sv */
// LFSR reseeded at every LOAD, holds between runs; stream bits are combinational from its state
`timescale 1ns/1ns

module sc_stream_gen import sc_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  logic     run,
  input  operand_t operand_a,
  input  operand_t operand_b,
  output logic     bit_a,
  output logic     bit_a_alt,
  output logic     bit_b,
  output logic     bit_sel
);

  lfsr_t    lfsr;
  logic     fb;          // Feedback into bit 0
  operand_t sel_slice;   // Scrambled slice for the adder select

  assign fb = lfsr[LFSR_TAP_HI] ^ lfsr[LFSR_TAP_LO];

  // Shift toward the high bit, one step per RUN cycle
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      lfsr <= LFSR_SEED;
    end else if (load) begin
      lfsr <= LFSR_SEED;   // Same sequence every run
    end else if (run) begin
      lfsr <= {lfsr[29:0], fb};
    end
  end

  // Select slice mixes low, high and middle bits
  assign sel_slice = {lfsr[3:1], lfsr[30:26], lfsr[11]};

  // Comparators, bit high when random slice below reference
  assign bit_a     = (lfsr[8:0]   < operand_a);
  assign bit_a_alt = (lfsr[20:12] < operand_a);  // Shares slice with bit_b
  assign bit_b     = (lfsr[20:12] < operand_b);
  assign bit_sel   = (sel_slice   < SEL_THRESHOLD);

endmodule

/* logic/sc_bitstream_ops.sv */
// Bipolar bitstream operators; squarer delay only advances in RUN
`timescale 1ns/1ns

module sc_bitstream_ops (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic run,
  input  logic bit_a,
  input  logic bit_a_alt,
  input  logic bit_b,
  input  logic bit_sel,
  output logic mul_bit,
  output logic add_bit,
  output logic sqr_bit
);

  logic a_dly;   // bit_a from previous RUN cycle

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      a_dly <= 1'b0;
    end else if (load) begin
      a_dly <= 1'b0;     // Zero in first RUN cycle
    end else if (run) begin
      a_dly <= bit_a;
    end
  end

  // XNOR is the bipolar product
  assign mul_bit = ~(bit_a ^ bit_b);

  // Mux with p(sel) = 1/2 gives the scaled sum
  assign add_bit = bit_sel ? bit_b : bit_a;

  // Delayed copy decorrelates the two streams of A
  assign sqr_bit = ~(bit_a_alt ^ a_dly);

endmodule

/* logic/sc_accumulators.sv */
// Ones counters over a 2^L window; result is count >> (L-8) clamped at 511, held until next capture
`timescale 1ns/1ns

module sc_accumulators import sc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load,
  input  logic      run,
  input  logic      last,
  input  win_log2_t win_log2,
  input  logic      mul_bit,
  input  logic      add_bit,
  input  logic      sqr_bit,
  output operand_t  res_mul,
  output operand_t  res_add,
  output operand_t  res_sqr
);

  logic [2:0] op_bits;     // Index 0 mul, 1 add, 2 sqr
  count_t     cnt [3];
  count_t     total [3];   // Count including this cycle's bit
  count_t     scaled [3];
  operand_t   res [3];
  win_log2_t  shift;

  assign op_bits = {sqr_bit, add_bit, mul_bit};
  assign shift   = win_log2 - WIN_LOG2_MIN;  // L is never below 8

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      total[i]  = cnt[i] + count_t'(op_bits[i]);
      scaled[i] = total[i] >> shift;
    end
  end

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
        res[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (load)
          cnt[i] <= '0;
        else if (run)
          cnt[i] <= total[i];
        // Capture on final cycle, saturate to 9 bits
        if (last) begin
          if (scaled[i] > count_t'(RESULT_MAX))
            res[i] <= RESULT_MAX;
          else
            res[i] <= operand_t'(scaled[i]);
        end
      end
    end
  end

  assign res_mul = res[0];
  assign res_add = res[1];
  assign res_sqr = res[2];

endmodule

/* logic/sc_top.sv */
// Stochastic mul/add/square core behind APB; one run at a time, results valid once STATUS.done is set
`timescale 1ns/1ns

module sc_top import sc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  operand_t  operand_a;
  operand_t  operand_b;
  win_log2_t win_log2;
  logic      start;
  logic      load;
  logic      run;
  logic      last;
  logic      busy;
  logic      done;
  logic      bit_a;
  logic      bit_a_alt;
  logic      bit_b;
  logic      bit_sel;
  logic      mul_bit;
  logic      add_bit;
  logic      sqr_bit;
  operand_t  res_mul;
  operand_t  res_add;
  operand_t  res_sqr;

  // Register block
  sc_apb_regs u_regs (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .busy(busy), .done(done), .res_mul(res_mul),
    .res_add(res_add), .res_sqr(res_sqr), .operand_a(operand_a),
    .operand_b(operand_b), .win_log2(win_log2), .start(start)
  );

  // Window sequencing
  sc_window_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .win_log2(win_log2), .load(load),
    .run(run), .last(last), .busy(busy), .done(done)
  );

  // Datapath, LFSR -> bit ops -> counters
  sc_stream_gen u_gen (
    .clk(clk), .rst_n(rst_n), .load(load), .run(run), .operand_a(operand_a),
    .operand_b(operand_b), .bit_a(bit_a), .bit_a_alt(bit_a_alt), .bit_b(bit_b),
    .bit_sel(bit_sel)
  );

  sc_bitstream_ops u_ops (
    .clk(clk), .rst_n(rst_n), .load(load), .run(run), .bit_a(bit_a),
    .bit_a_alt(bit_a_alt), .bit_b(bit_b), .bit_sel(bit_sel), .mul_bit(mul_bit),
    .add_bit(add_bit), .sqr_bit(sqr_bit)
  );

  sc_accumulators u_acc (
    .clk(clk), .rst_n(rst_n), .load(load), .run(run), .last(last),
    .win_log2(win_log2), .mul_bit(mul_bit), .add_bit(add_bit), .sqr_bit(sqr_bit),
    .res_mul(res_mul), .res_add(res_add), .res_sqr(res_sqr)
  );

endmodule

/* sim/sc_ref_model.svh */
// Bit-exact model of one run from reseed; L assumed within 8..17, cost grows with 2^L per call
`ifndef SC_REF_MODEL_SVH
`define SC_REF_MODEL_SVH

// Count scaled back to 9 bits, clamped at full scale
function automatic logic [8:0] scale_count(input int n, input int l);
  int v;
  v = n >> (l - 8);
  if (v > 511)
    return 9'd511;
  return v[8:0];
endfunction

function automatic void ref_results(input logic [8:0] a, input logic [8:0] b, input int l,
                                    output logic [8:0] mul, output logic [8:0] add,
                                    output logic [8:0] sqr);
  logic [30:0] s;
  logic [8:0]  sel_slice;
  logic        ba;
  logic        baa;
  logic        bb;
  logic        bs;
  logic        a_prev;     // bit_a one cycle back
  int          n_mul;
  int          n_add;
  int          n_sqr;
  s      = 31'd134995;     // Seed reloaded every run
  a_prev = 1'b0;
  n_mul  = 0;
  n_add  = 0;
  n_sqr  = 0;
  for (int i = 0; i < (1 << l); i++) begin
    ba        = (s[8:0] < a);
    baa       = (s[20:12] < a);
    bb        = (s[20:12] < b);
    sel_slice = {s[3:1], s[30:26], s[11]};
    bs        = (sel_slice < 9'd256);
    if (ba == bb)
      n_mul++;               // XNOR product
    if (bs ? bb : ba)
      n_add++;               // Weighted average
    if (baa == a_prev)
      n_sqr++;
    a_prev = ba;
    s      = {s[29:0], s[30] ^ s[27]};  // Step after bits are used
  end
  mul = scale_count(n_mul, l);
  add = scale_count(n_add, l);
  sqr = scale_count(n_sqr, l);
endfunction

`endif

/* sim/sc_tb.sv */
// Self-checking testbench for sc_top; APB with no wait states, runs use L of 8 and 10 only
`timescale 1ns/1ns

module sc_tb import sc_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  // Eight runs at L=8 and two at L=10, each with APB margin
  localparam int RUN_BUDGET      = 8 * (256 + 50) + 2 * (1024 + 50);
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * RUN_BUDGET;

  logic      clk;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  integer    seed;
  int        fail_count;

  `include "sc_ref_model.svh"

  sc_top u_sc_top (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;   // 4 ns period

  task automatic check(input string name, input apb_data_t expected, input apb_data_t actual);
    if (expected !== actual) begin
      fail_count++;
      $display("mismatch %s expected=0x%0h actual=0x%0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "check %s failed", name);
    end
  endtask

  // Setup then access phase, response sampled mid access cycle
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check("pready in access phase", 32'h1, apb_data_t'(pready));  // No wait states
    @(posedge clk);     // Transfer takes effect here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic read_expect(input string name, input apb_addr_t addr,
                             input apb_data_t expected, output apb_data_t data);
    logic err;
    apb_read(addr, data, err);
    check({name, " pslverr"}, '0, apb_data_t'(err));
    check(name, expected, data);
  endtask

  function automatic apb_data_t ctrl_word(input int l, input logic go);
    return (apb_data_t'(l) << CTRL_L_LSB) | apb_data_t'(go);
  endfunction

  task automatic start_run(input operand_t a, input operand_t b, input int l);
    logic err;
    apb_write(ADDR_OPERAND_A, apb_data_t'(a), err);
    check("write a pslverr", '0, apb_data_t'(err));
    apb_write(ADDR_OPERAND_B, apb_data_t'(b), err);
    check("write b pslverr", '0, apb_data_t'(err));
    apb_write(ADDR_CTRL, ctrl_word(l, 1'b1), err);
    check("start pslverr", '0, apb_data_t'(err));
  endtask

  task automatic wait_done();
    apb_data_t rdata;
    logic      err;
    do begin
      apb_read(ADDR_STATUS, rdata, err);    // Watchdog bounds this loop
    end while (!rdata[STATUS_DONE_BIT]);
  endtask

  // Reads all three results and compares with the model
  task automatic compare_results(input string name, input operand_t a, input operand_t b,
                                 input int l, output apb_data_t res [3]);
    operand_t exp_m;
    operand_t exp_ad;
    operand_t exp_sq;
    ref_results(a, b, l, exp_m, exp_ad, exp_sq);
    read_expect({name, " mul"}, ADDR_RES_MUL, apb_data_t'(exp_m), res[0]);
    read_expect({name, " add"}, ADDR_RES_ADD, apb_data_t'(exp_ad), res[1]);
    read_expect({name, " sqr"}, ADDR_RES_SQR, apb_data_t'(exp_sq), res[2]);
  endtask

  task automatic run_and_compare(input string name, input operand_t a, input operand_t b,
                                 input int l);
    apb_data_t res [3];
    start_run(a, b, l);
    wait_done();
    compare_results(name, a, b, l, res);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    apb_data_t   rdata;
    apb_data_t   first [3];
    apb_data_t   again [3];
    logic        err;
    operand_t    a;
    operand_t    b;
    logic [31:0] rnd;
    seed       = 32'hdfe1;
    fail_count = 0;
    rst_n      = 1'b1;   // Reset is active high
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b0;

    // Reset values
    read_expect("reset operand a", ADDR_OPERAND_A, '0, rdata);
    read_expect("reset operand b", ADDR_OPERAND_B, '0, rdata);
    read_expect("reset status", ADDR_STATUS, '0, rdata);
    read_expect("reset res mul", ADDR_RES_MUL, '0, rdata);
    read_expect("reset res add", ADDR_RES_ADD, '0, rdata);
    read_expect("reset res sqr", ADDR_RES_SQR, '0, rdata);

    for (int i = 0; i < 5; i++) begin
      rnd = $random(seed);
      a   = rnd[8:0];
      rnd = $random(seed);
      b   = rnd[8:0];
      run_and_compare($sformatf("l8 pair %0d", i), a, b, 8);
    end
    for (int i = 0; i < 2; i++) begin
      rnd = $random(seed);
      a   = rnd[8:0];
      rnd = $random(seed);
      b   = rnd[8:0];
      run_and_compare($sformatf("l10 pair %0d", i), a, b, 10);   // Shift by 2
    end
    run_and_compare("full scale", 9'd511, 9'd511, 8);

    // Rejected traffic during and after a run
    a = 9'h0a5;
    b = 9'h13c;
    start_run(a, b, 8);
    apb_write(ADDR_OPERAND_A, 32'h0000_0033, err);
    check("write a while busy pslverr", 32'h1, apb_data_t'(err));
    read_expect("operand a after rejected write", ADDR_OPERAND_A, apb_data_t'(a), rdata);
    apb_write(ADDR_CTRL, ctrl_word(9, 1'b1), err);
    check("start while busy pslverr", 32'h1, apb_data_t'(err));
    read_expect("ctrl after rejected start", ADDR_CTRL, ctrl_word(8, 1'b0), rdata);
    wait_done();
    compare_results("run with rejected traffic", a, b, 8, first);
    apb_write(ADDR_CTRL, ctrl_word(18, 1'b1), err);
    check("start with l 18 pslverr", 32'h1, apb_data_t'(err));
    read_expect("status after l 18 start", ADDR_STATUS, 32'h2, rdata);   // Done, not busy
    read_expect("ctrl after l 18 start", ADDR_CTRL, ctrl_word(8, 1'b0), rdata);
    apb_write(8'h40, 32'hdead_beef, err);
    check("write 0x40 pslverr", 32'h1, apb_data_t'(err));
    apb_read(8'h40, rdata, err);
    check("read 0x40 pslverr", 32'h1, apb_data_t'(err));
    read_expect("operand a after 0x40", ADDR_OPERAND_A, apb_data_t'(a), rdata);
    read_expect("operand b after 0x40", ADDR_OPERAND_B, apb_data_t'(b), rdata);
    read_expect("res mul after 0x40", ADDR_RES_MUL, first[0], rdata);

    // Restart clears done, same seed gives same results
    apb_write(ADDR_CTRL, ctrl_word(8, 1'b1), err);
    check("restart pslverr", '0, apb_data_t'(err));
    read_expect("status after restart", ADDR_STATUS, 32'h1, rdata);
    wait_done();
    compare_results("repeat run", a, b, 8, again);
    check("repeat mul", first[0], again[0]);
    check("repeat add", first[1], again[1]);
    check("repeat sqr", first[2], again[2]);

    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sc_top.f */
+incdir+sim
logic/sc_pkg.sv
logic/sc_apb_regs.sv
logic/sc_window_ctrl.sv
logic/sc_stream_gen.sv
logic/sc_bitstream_ops.sv
logic/sc_accumulators.sv
logic/sc_top.sv
sim/sc_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing --assert --top-module sc_tb -f sc_top.f -o sc_sim || exit 1
out=$(./obj_dir/sc_sim 2>&1)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "simulation ok" ||
  { echo "simulation failed"; exit 1; }
